// File: build.f
rv_fetch_pkg.sv
next_pc_predictor.sv
fetch_unit.sv
imem_model.sv
fetch_top.sv
fetch_assertions.sv
tb_fetch_top.sv

// File: fetch_assertions.sv
`timescale 1ns/1ps

module fetch_assertions (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       mem_req,
    input logic                       inst_valid,
    input logic                       lsb_full,
    input logic                       iq_full,
    input rv_fetch_pkg::fetch_state_t state
);

    int fail_count = 0; // Read by the testbench at the end

    // ======================================================================
    // Request protocol
    // ======================================================================
    // FS_WAIT spans the whole memory latency and blocks further requests
    req_not_waiting: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(mem_req) || $past(mem_req, rv_fetch_pkg::IMEM_LATENCY))
        |-> state == rv_fetch_pkg::FS_WAIT && !mem_req)
    else begin
        fail_count++;
        $error("mem_req raised or FS_WAIT left with a request already outstanding");
    end

    // Every delivered instruction was requested with both levels low
    req_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid |-> !$past(lsb_full, rv_fetch_pkg::IMEM_LATENCY + 1)
                    && !$past(iq_full, rv_fetch_pkg::IMEM_LATENCY + 1))
    else begin
        fail_count++;
        $error("Instruction delivered for a request made while a full level was high");
    end

    // Quiet first cycle out of reset
    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !mem_req && !inst_valid)
    else begin
        fail_count++;
        $error("mem_req or inst_valid high in the first cycle after reset");
    end

endmodule

bind fetch_unit fetch_assertions u_fetch_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_req    (mem_req),
    .inst_valid (inst_valid),
    .lsb_full   (lsb_full),
    .iq_full    (iq_full),
    .state      (state)
);

// File: fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     branch_taken,
    input  rv_fetch_pkg::xlen_t      branch_pc,
    input  logic                     jalr_ready,
    input  rv_fetch_pkg::xlen_t      jalr_addr,
    input  logic                     lsb_full,
    input  logic                     iq_full,
    input  logic                     load_en,
    input  rv_fetch_pkg::imem_addr_t load_addr,
    input  rv_fetch_pkg::inst_t      load_data,
    output logic                     inst_valid,
    output rv_fetch_pkg::inst_t      inst,
    output rv_fetch_pkg::xlen_t      inst_pc
);

    // Fetch to memory request and response
    logic                mem_req;
    rv_fetch_pkg::xlen_t mem_addr;
    logic                mem_valid;
    rv_fetch_pkg::inst_t mem_data;

    fetch_unit u_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_valid    (mem_valid),
        .mem_data     (mem_data),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc),
        .jalr_ready   (jalr_ready),
        .jalr_addr    (jalr_addr),
        .lsb_full     (lsb_full),
        .iq_full      (iq_full),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_pc      (inst_pc)
    );

    imem_model u_imem (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_en     (mem_req),
        .rd_addr   (mem_addr),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_valid  (mem_valid),
        .rd_data   (mem_data)
    );

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mem_valid,
    input  rv_fetch_pkg::inst_t mem_data,
    input  logic                branch_taken,
    input  rv_fetch_pkg::xlen_t branch_pc,
    input  logic                jalr_ready,
    input  rv_fetch_pkg::xlen_t jalr_addr,
    input  logic                lsb_full,
    input  logic                iq_full,
    output logic                mem_req,
    output rv_fetch_pkg::xlen_t mem_addr,
    output logic                inst_valid,
    output rv_fetch_pkg::inst_t inst,
    output rv_fetch_pkg::xlen_t inst_pc
);

    rv_fetch_pkg::fetch_state_t state;
    rv_fetch_pkg::xlen_t        fetch_pc;     // Address of the next request
    rv_fetch_pkg::xlen_t        req_pc;       // Address of the outstanding request
    logic                       drop;         // Outstanding response is stale
    logic                       fetch_en;     // Low for one cycle after reset
    logic                       redirect;
    rv_fetch_pkg::xlen_t        redirect_pc;
    logic                       accept;
    rv_fetch_pkg::xlen_t        pred_pc;
    logic                       pred_halt;

    // ======================================================================
    // Redirect select and request strobe
    // ======================================================================
    assign redirect    = jalr_ready | branch_taken;
    assign redirect_pc = jalr_ready ? jalr_addr : branch_pc; // JALR has priority

    // No request in a redirect cycle, the new PC lands at the clock edge
    assign mem_req = fetch_en
                  && (state == rv_fetch_pkg::FS_IDLE)
                  && !lsb_full
                  && !iq_full
                  && !redirect;
    assign mem_addr = fetch_pc;

    // Response is kept unless an older or a same-cycle redirect made it stale
    assign accept = (state == rv_fetch_pkg::FS_WAIT) && mem_valid && !drop && !redirect;

    next_pc_predictor u_pred (
        .inst      (mem_data),
        .pc        (req_pc),
        .pred_pc   (pred_pc),
        .pred_halt (pred_halt)
    );

    // ======================================================================
    // Request FSM and fetch PC
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= rv_fetch_pkg::FS_IDLE;
            fetch_pc   <= rv_fetch_pkg::RESET_PC;
            drop       <= 1'b0;
            fetch_en   <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            fetch_en   <= 1'b1;
            inst_valid <= accept;

            case (state)
                rv_fetch_pkg::FS_IDLE: begin
                    if (mem_req) begin
                        state <= rv_fetch_pkg::FS_WAIT;
                    end
                end
                rv_fetch_pkg::FS_WAIT: begin
                    if (mem_valid) begin
                        drop <= 1'b0;
                        if (accept && pred_halt) begin
                            state <= rv_fetch_pkg::FS_HALT;
                        end else begin
                            state <= rv_fetch_pkg::FS_IDLE;
                        end
                    end else if (redirect) begin
                        drop <= 1'b1; // Response still on its way
                    end
                end
                rv_fetch_pkg::FS_HALT: begin
                    if (redirect) begin
                        state <= rv_fetch_pkg::FS_IDLE;
                    end
                end
                default: begin
                    state <= rv_fetch_pkg::FS_IDLE;
                end
            endcase

            if (redirect) begin
                fetch_pc <= redirect_pc;
            end else if (accept) begin
                fetch_pc <= pred_pc;
            end
        end
    end

    // ======================================================================
    // Request address and instruction output
    // ======================================================================
    always_ff @(posedge clk) begin
        if (mem_req) begin
            req_pc <= fetch_pc;
        end
        if (accept) begin
            inst    <= mem_data;
            inst_pc <= req_pc;
        end
    end

endmodule

// File: imem_model.sv
`timescale 1ns/1ps

module imem_model (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     rd_en,
    input  rv_fetch_pkg::xlen_t      rd_addr,
    input  logic                     load_en,
    input  rv_fetch_pkg::imem_addr_t load_addr,
    input  rv_fetch_pkg::inst_t      load_data,
    output logic                     rd_valid,
    output rv_fetch_pkg::inst_t      rd_data
);

    localparam int LAT = rv_fetch_pkg::IMEM_LATENCY;

    rv_fetch_pkg::inst_t      mem        [rv_fetch_pkg::IMEM_WORDS];
    logic                     valid_pipe [LAT];
    rv_fetch_pkg::inst_t      data_pipe  [LAT];
    rv_fetch_pkg::imem_addr_t rd_word;

    // Byte address to word index
    assign rd_word = rd_addr[rv_fetch_pkg::IMEM_AW+1:2];

    // ======================================================================
    // Load port
    // ======================================================================
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // ======================================================================
    // Read pipeline
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < LAT; i++) begin
                valid_pipe[i] <= 1'b0;
            end
        end else begin
            valid_pipe[0] <= rd_en;
            for (int i = 1; i < LAT; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            data_pipe[0] <= mem[rd_word]; // Array read in the first stage
        end
        for (int i = 1; i < LAT; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign rd_valid = valid_pipe[LAT-1];
    assign rd_data  = data_pipe[LAT-1];

endmodule

// File: next_pc_predictor.sv
`timescale 1ns/1ps

module next_pc_predictor (
    input  rv_fetch_pkg::inst_t inst,
    input  rv_fetch_pkg::xlen_t pc,
    output rv_fetch_pkg::xlen_t pred_pc,
    output logic                pred_halt
);

    rv_fetch_pkg::opcode_t opcode;
    rv_fetch_pkg::xlen_t   j_imm;
    rv_fetch_pkg::xlen_t   seq_pc;
    rv_fetch_pkg::xlen_t   jal_pc;

    assign opcode = inst[6:0];

    // J-type immediate, reassembled from inst[31:12] and sign extended
    assign j_imm = {
        {12{inst[31]}},
        inst[19:12],
        inst[20],
        inst[30:21],
        1'b0
    };

    assign seq_pc = pc + rv_fetch_pkg::INST_BYTES;
    assign jal_pc = pc + j_imm;

    always_comb begin
        pred_pc   = seq_pc;
        pred_halt = 1'b0;
        case (opcode)
            rv_fetch_pkg::OPC_JAL: begin
                pred_pc = jal_pc;
            end
            rv_fetch_pkg::OPC_JALR: begin
                // Target depends on a register, wait for execute
                pred_halt = 1'b1;
            end
            default: begin
                pred_pc = seq_pc; // Branches predicted not taken
            end
        endcase
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
    --top-module tb_fetch_top \
    -Mdir "$OBJ" -o sim_fetch \
    -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/sim_fetch" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// File: rv_fetch_pkg.sv
package rv_fetch_pkg;

    // ======================================================================
    // Datapath widths
    // ======================================================================
    typedef logic [31:0] xlen_t;   // Addresses and PCs
    typedef logic [31:0] inst_t;   // One instruction word
    typedef logic [6:0]  opcode_t;

    localparam xlen_t INST_BYTES = 32'd4;
    localparam xlen_t RESET_PC   = 32'h0000_0000;

    // Control-transfer opcodes seen by the predictor
    localparam opcode_t OPC_JAL  = 7'b1101111;
    localparam opcode_t OPC_JALR = 7'b1100111;

    // ======================================================================
    // Instruction memory sizing
    // ======================================================================
    localparam int IMEM_AW      = 8;              // Word address width
    localparam int IMEM_WORDS   = 2 ** IMEM_AW;   // 256 words
    localparam int IMEM_LATENCY = 2;              // Read latency in cycles

    typedef logic [IMEM_AW-1:0] imem_addr_t;

    // ======================================================================
    // Fetch request state
    // ======================================================================
    typedef enum logic [1:0] {
        FS_IDLE = 2'd0,   // Free to issue a request
        FS_WAIT = 2'd1,   // One request outstanding
        FS_HALT = 2'd2    // Stopped behind a JALR
    } fetch_state_t;

endpackage

// File: tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;

    localparam int CLK_PERIOD = 20;

    // Program landmarks, byte addresses
    localparam rv_fetch_pkg::xlen_t JALR_PC     = 32'h0000_00A8; // Word 42
    localparam rv_fetch_pkg::xlen_t JALR_TARGET = 32'h0000_0100; // Word 64
    localparam rv_fetch_pkg::xlen_t LOSING_PC   = 32'h0000_0300; // Same-cycle branch, must lose
    localparam rv_fetch_pkg::xlen_t LOOP_PC     = 32'h0000_0200; // Word 128

    localparam int STALL_INSTS = 100;

    // Cycle budget per test, used by the watchdog
    localparam int LOAD_CYCLES     = rv_fetch_pkg::IMEM_WORDS + 4;
    localparam int PATH_CYCLES     = 20 * 4;
    localparam int HALT_CYCLES     = 12;
    localparam int REDIRECT_CYCLES = 3 * 10 * 4;
    localparam int STALL_CYCLES    = STALL_INSTS * 4 * 4;
    localparam int TAIL_CYCLES     = 12 * 4;
    localparam int TEST_CYCLES     = LOAD_CYCLES + PATH_CYCLES + HALT_CYCLES
                                   + REDIRECT_CYCLES + STALL_CYCLES + TAIL_CYCLES;
    localparam int WATCHDOG_NS     = (TEST_CYCLES + 500) * CLK_PERIOD;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     branch_taken;
    rv_fetch_pkg::xlen_t      branch_pc;
    logic                     jalr_ready;
    rv_fetch_pkg::xlen_t      jalr_addr;
    logic                     lsb_full;
    logic                     iq_full;
    logic                     load_en;
    rv_fetch_pkg::imem_addr_t load_addr;
    rv_fetch_pkg::inst_t      load_data;
    logic                     inst_valid;
    rv_fetch_pkg::inst_t      inst;
    rv_fetch_pkg::xlen_t      inst_pc;

    rv_fetch_pkg::inst_t prog [rv_fetch_pkg::IMEM_WORDS];

    rv_fetch_pkg::xlen_t exp_pc = rv_fetch_pkg::RESET_PC;
    logic                exp_halt = 1'b0;
    int                  errors = 0;
    int                  checks = 0;
    int                  cycle = 0;
    int                  first_req_cycle = -1;
    logic                seen_first = 1'b0;

    fetch_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc),
        .jalr_ready   (jalr_ready),
        .jalr_addr    (jalr_addr),
        .lsb_full     (lsb_full),
        .iq_full      (iq_full),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_pc      (inst_pc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ======================================================================
    // Program image and reference model
    // ======================================================================
    function automatic rv_fetch_pkg::inst_t jal_word(input int off);
        logic [20:0] imm;
        imm = off[20:0];
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, rv_fetch_pkg::OPC_JAL};
    endfunction

    function automatic logic is_jalr(input rv_fetch_pkg::inst_t w);
        return w[6:0] == rv_fetch_pkg::OPC_JALR;
    endfunction

    function automatic rv_fetch_pkg::inst_t word_at(input rv_fetch_pkg::xlen_t pc);
        return prog[pc[rv_fetch_pkg::IMEM_AW+1:2]];
    endfunction

    // JAL jumps, everything else falls through (branches not taken)
    function automatic rv_fetch_pkg::xlen_t next_expected_pc(input rv_fetch_pkg::xlen_t pc);
        rv_fetch_pkg::inst_t w;
        logic [20:0]         off;
        w = word_at(pc);
        if (w[6:0] == rv_fetch_pkg::OPC_JAL) begin
            off = {w[31], w[19:12], w[20], w[30:21], 1'b0};
            return pc + {{11{off[20]}}, off};
        end
        return pc + 32'd4;
    endfunction

    task automatic build_program();
        rv_fetch_pkg::imem_addr_t a;
        for (int w = 0; w < rv_fetch_pkg::IMEM_WORDS; w++) begin
            a = rv_fetch_pkg::imem_addr_t'(w);
            prog[w] = {4'h0, a, 5'd1, 3'b000, 5'd1, 7'b0010011}; // addi x1, x1, w
        end
        prog[8]   = jal_word(64);     // To word 24
        prog[25]  = {7'd0, 5'd2, 5'd1, 3'b000, 5'b01000, 7'b1100011}; // beq
        prog[26]  = jal_word(-56);    // Back to word 12
        prog[16]  = jal_word(96);     // To word 40
        prog[41]  = {20'h00001, 5'd3, 7'b0010111}; // auipc, plain fall through
        prog[42]  = {12'd0, 5'd1, 3'b000, 5'd0, rv_fetch_pkg::OPC_JALR};
        prog[200] = jal_word(-288);   // Loop back to word 128
    endtask

    // ======================================================================
    // Stimulus helpers
    // ======================================================================
    task automatic load_program();
        for (int w = 0; w < rv_fetch_pkg::IMEM_WORDS; w++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= rv_fetch_pkg::imem_addr_t'(w);
            load_data <= prog[w];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic wait_inst();
        @(posedge clk);
        while (!inst_valid) @(posedge clk);
    endtask

    task automatic wait_insts(input int n);
        repeat (n) wait_inst();
    endtask

    task automatic wait_for_pc(input rv_fetch_pkg::xlen_t pc);
        @(posedge clk);
        while (!(inst_valid && inst_pc == pc)) @(posedge clk);
    endtask

    // Gap 0 hits the request before its response, gap 1 the response cycle
    // Gap 2 finds the unit idle
    task automatic redirect_after_inst(input rv_fetch_pkg::xlen_t target, input int gap);
        wait_inst();
        repeat (gap) @(posedge clk);
        branch_taken <= 1'b1;
        branch_pc    <= target;
        @(posedge clk);
        branch_taken <= 1'b0;
    endtask

    // ======================================================================
    // Compare process
    // ======================================================================
    always @(posedge clk) begin
        cycle++;
        if (rst_n) begin
            if (DUT.u_fetch.mem_req && first_req_cycle < 0) begin
                first_req_cycle = cycle;
            end
            if (inst_valid) begin
                checks++;
                if (!seen_first) begin
                    seen_first = 1'b1;
                    assert (cycle - first_req_cycle == 3) else begin
                        errors++;
                        $display("First inst_valid came %0d cycles after the first request",
                                 cycle - first_req_cycle);
                    end
                end
                assert (!exp_halt) else begin
                    errors++;
                    $display("An instruction was delivered while fetch waited on a JALR");
                end
                assert (inst_pc === exp_pc) else begin
                    errors++;
                    $display("Error inst_pc: got 0x%h expected 0x%h", inst_pc, exp_pc);
                end
                assert (inst === word_at(exp_pc)) else begin
                    errors++;
                    $display("Error inst: got 0x%h expected 0x%h", inst, word_at(exp_pc));
                end
                if (is_jalr(word_at(exp_pc))) begin
                    exp_halt = 1'b1;
                end
                exp_pc = next_expected_pc(exp_pc);
            end
            // Redirect seen after any instruction of the old path
            if (jalr_ready) begin
                exp_pc   = jalr_addr;
                exp_halt = 1'b0;
            end else if (branch_taken) begin
                exp_pc   = branch_pc;
                exp_halt = 1'b0;
            end
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        int stall_count;
        int assert_fails;
        rst_n        = 1'b0;
        branch_taken = 1'b0;
        branch_pc    = '0;
        jalr_ready   = 1'b0;
        jalr_addr    = '0;
        lsb_full     = 1'b0;
        iq_full      = 1'b0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        void'($urandom(97));

        build_program();
        load_program();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Sequential fetch and JAL/branch prediction up to the JALR
        wait_for_pc(JALR_PC);
        repeat (8) @(posedge clk);
        jalr_ready   <= 1'b1;
        jalr_addr    <= JALR_TARGET;
        branch_taken <= 1'b1;
        branch_pc    <= LOSING_PC;
        @(posedge clk);
        jalr_ready   <= 1'b0;
        branch_taken <= 1'b0;

        // Branch redirects while a request is in flight, then at a random gap
        wait_insts(4);
        redirect_after_inst(32'h0000_0180, 0);
        wait_insts(4);
        redirect_after_inst(32'h0000_0120, 1);
        wait_insts(4);
        redirect_after_inst(LOOP_PC, int'($urandom % 3));

        // Back-pressure over the loop
        wait_insts(2);
        stall_count = 0;
        while (stall_count < STALL_INSTS) begin
            @(posedge clk);
            if (inst_valid) stall_count++;
            lsb_full <= ($urandom % 4) == 0;
            iq_full  <= ($urandom % 5) == 0;
        end
        @(posedge clk);
        lsb_full <= 1'b0;
        iq_full  <= 1'b0;
        wait_insts(8);
        repeat (4) @(posedge clk);

        assert_fails = DUT.u_fetch.u_fetch_assert.fail_count;
        $display("Checks %0d, compare errors %0d, assertion failures %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

endmodule
